//--- hdl/uart_link_pkg.sv
// UART link definitions: default bit timing, data width and byte type
package uart_link_pkg;

  // ==========================================================
  // Bit timing
  // ==========================================================
  // 25 MHz core clock at roughly 921600 baud
  parameter int CLKS_PER_BIT_DEFAULT = 27;

  // ==========================================================
  // Frame format
  // ==========================================================
  parameter int DATA_BITS = 8;           // 8N1, no parity

  // One byte on the serial line
  typedef logic [DATA_BITS-1:0] byte_t;

endpackage

//--- hdl/sensor_cmd_pkg.sv
// Sensor command opcodes, controller states, command and report word types
package sensor_cmd_pkg;

  // ==========================================================
  // PC link opcodes (ASCII)
  // ==========================================================
  typedef enum logic [7:0] {
    CMD_MPR_DATA   = 8'h4D,  // 'M' MPR sample report
    CMD_MPR_READ   = 8'h6D,  // 'm' MPR register read
    CMD_ADS_DATA   = 8'h41,  // 'A' ADS sample report
    CMD_ADS_READ   = 8'h61,  // 'a' ADS register read
    CMD_RUN        = 8'h52,  // 'R'
    CMD_STOP       = 8'h53,  // 'S'
    CMD_ADS_FINISH = 8'h46,  // 'F'
    CMD_MPR_FINISH = 8'h66   // 'f'
  } cmd_e;

  // Controller FSM
  typedef enum logic [2:0] {
    ST_IDLE,     // Waiting for RX byte or report word
    ST_RX_ADDR,  // Second byte of a register read
    ST_TX_INIT,  // Header decode
    ST_TX_SEND,  // Hand one byte to the TX engine
    ST_TX_WAIT   // Wait for TX done
  } ctrl_state_e;

  // Bytes sent per report header
  parameter int REPORT_LONG_BYTES  = 5;  // 'A'
  parameter int REPORT_SHORT_BYTES = 3;  // 'M', 'm', 'a'

  // Command word to the core, opcode on top
  typedef struct packed {
    cmd_e                 opcode;
    uart_link_pkg::byte_t addr;    // Zero for single-byte commands
  } cmd_word_t;

  // Report word from the core, sent MSB byte first
  typedef struct packed {
    uart_link_pkg::byte_t header;
    logic [31:0]          payload;
  } report_word_t;

endpackage

//--- hdl/uart_phy_if.sv
// Byte-level bus between the command controller and the UART engines
`timescale 1ns/1ps

interface uart_phy_if;

  // Transmit direction
  logic                 tx_dv;    // One-cycle start strobe
  uart_link_pkg::byte_t tx_byte;
  logic                 tx_done;  // Pulse after stop bit

  // Receive direction
  logic                 rx_dv;    // One-cycle byte strobe
  uart_link_pkg::byte_t rx_byte;  // Valid with rx_dv

  modport ctrl (
    output tx_dv,
    output tx_byte,
    input  tx_done,
    input  rx_dv,
    input  rx_byte
  );

  modport tx (input tx_dv, input tx_byte, output tx_done);

  modport rx (output rx_dv, output rx_byte);

endinterface

//--- hdl/uart_tx.sv
// UART transmit engine, 8N1 serializer with one-cycle done pulse
`timescale 1ns/1ps

module uart_tx #(
  parameter int CLKS_PER_BIT = uart_link_pkg::CLKS_PER_BIT_DEFAULT
) (
  input  logic   i_CLK,
  input  logic   i_RST,
  uart_phy_if.tx phy,
  output logic   o_txd
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
  localparam int IDX_W = $clog2(uart_link_pkg::DATA_BITS);
  localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(CLKS_PER_BIT - 1);
  localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(uart_link_pkg::DATA_BITS - 1);

  typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_e;

  tx_state_e            r_state;
  logic [CNT_W-1:0]     r_clk_cnt;  // Clocks within current bit
  logic [IDX_W-1:0]     r_bit_idx;  // Data bit being sent
  uart_link_pkg::byte_t r_data;     // Shifts right, bit 0 is next out

  // ==========================================================
  // Bit sequencer
  // ==========================================================
  always_ff @(posedge i_CLK or posedge i_RST) begin
    if (i_RST) begin
      r_state     <= TX_IDLE;
      r_clk_cnt   <= '0;
      r_bit_idx   <= '0;
      o_txd       <= 1'b1;  // Line idles high
      phy.tx_done <= 1'b0;
    end else begin
      phy.tx_done <= 1'b0;
      case (r_state)
        TX_IDLE: begin
          o_txd     <= 1'b1;
          r_clk_cnt <= '0;
          r_bit_idx <= '0;
          if (phy.tx_dv) begin
            o_txd   <= 1'b0;  // Start bit
            r_state <= TX_START;
          end
        end
        TX_START: begin
          if (r_clk_cnt == BIT_LAST) begin
            r_clk_cnt <= '0;
            o_txd     <= r_data[0];  // LSB first
            r_state   <= TX_DATA;
          end else begin
            r_clk_cnt <= r_clk_cnt + 1'b1;
          end
        end
        TX_DATA: begin
          if (r_clk_cnt == BIT_LAST) begin
            r_clk_cnt <= '0;
            if (r_bit_idx == IDX_LAST) begin
              o_txd   <= 1'b1;  // Stop bit
              r_state <= TX_STOP;
            end else begin
              r_bit_idx <= r_bit_idx + 1'b1;
              o_txd     <= r_data[1];  // r_data shifts on this edge
            end
          end else begin
            r_clk_cnt <= r_clk_cnt + 1'b1;
          end
        end
        TX_STOP: begin
          if (r_clk_cnt == BIT_LAST) begin
            phy.tx_done <= 1'b1;
            r_state     <= TX_IDLE;
          end else begin
            r_clk_cnt <= r_clk_cnt + 1'b1;
          end
        end
        default: r_state <= TX_IDLE;
      endcase
    end
  end

  // Data shifter
  always_ff @(posedge i_CLK) begin
    if (r_state == TX_IDLE && phy.tx_dv) begin
      r_data <= phy.tx_byte;
    end else if (r_state == TX_DATA && r_clk_cnt == BIT_LAST) begin
      r_data <= r_data >> 1;
    end
  end

endmodule

//--- hdl/uart_rx.sv
// UART receive engine, 8N1 deserializer with mid-bit sampling
`timescale 1ns/1ps

module uart_rx #(
  parameter int CLKS_PER_BIT = uart_link_pkg::CLKS_PER_BIT_DEFAULT
) (
  input  logic   i_CLK,
  input  logic   i_RST,
  input  logic   i_rxd,
  uart_phy_if.rx phy
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
  localparam int IDX_W = $clog2(uart_link_pkg::DATA_BITS);
  localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(CLKS_PER_BIT - 1);
  localparam logic [CNT_W-1:0] BIT_HALF = CNT_W'((CLKS_PER_BIT - 1) / 2);
  localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(uart_link_pkg::DATA_BITS - 1);

  typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

  rx_state_e            r_state;
  logic                 r_rxd_meta;  // First sync stage
  logic                 r_rxd_sync;  // Safe to use
  logic [CNT_W-1:0]     r_clk_cnt;
  logic [IDX_W-1:0]     r_bit_idx;
  uart_link_pkg::byte_t r_data;      // Fills from the top, LSB first

  // ==========================================================
  // Input synchronizer
  // ==========================================================
  always_ff @(posedge i_CLK or posedge i_RST) begin
    if (i_RST) begin
      r_rxd_meta <= 1'b1;
      r_rxd_sync <= 1'b1;
    end else begin
      r_rxd_meta <= i_rxd;
      r_rxd_sync <= r_rxd_meta;
    end
  end

  // ==========================================================
  // Frame FSM
  // ==========================================================
  always_ff @(posedge i_CLK or posedge i_RST) begin
    if (i_RST) begin
      r_state   <= RX_IDLE;
      r_clk_cnt <= '0;
      r_bit_idx <= '0;
      phy.rx_dv <= 1'b0;
    end else begin
      phy.rx_dv <= 1'b0;
      case (r_state)
        RX_IDLE: begin
          r_clk_cnt <= '0;
          r_bit_idx <= '0;
          if (!r_rxd_sync) r_state <= RX_START;  // Falling edge
        end
        RX_START: begin
          if (r_clk_cnt == BIT_HALF) begin
            r_clk_cnt <= '0;  // Realign to mid-bit
            // Glitch shorter than half a bit goes back to idle
            r_state   <= r_rxd_sync ? RX_IDLE : RX_DATA;
          end else begin
            r_clk_cnt <= r_clk_cnt + 1'b1;
          end
        end
        RX_DATA: begin
          if (r_clk_cnt == BIT_LAST) begin
            r_clk_cnt <= '0;
            if (r_bit_idx == IDX_LAST) r_state <= RX_STOP;
            else r_bit_idx <= r_bit_idx + 1'b1;
          end else begin
            r_clk_cnt <= r_clk_cnt + 1'b1;
          end
        end
        RX_STOP: begin
          // Middle of stop bit, level not checked
          if (r_clk_cnt == BIT_LAST) begin
            phy.rx_dv <= 1'b1;
            r_state   <= RX_IDLE;
          end else begin
            r_clk_cnt <= r_clk_cnt + 1'b1;
          end
        end
        default: r_state <= RX_IDLE;
      endcase
    end
  end

  // Sample at mid-bit
  always_ff @(posedge i_CLK) begin
    if (r_state == RX_DATA && r_clk_cnt == BIT_LAST) begin
      r_data <= {r_rxd_sync, r_data[uart_link_pkg::DATA_BITS-1:1]};
    end
  end

  assign phy.rx_byte = r_data;  // Stable while rx_dv is high

endmodule

//--- hdl/uart_controller.sv
// Command controller: RX command filter, read request assembly, report framing FSM
`timescale 1ns/1ps

module uart_controller (
  input  logic                        i_CLK,
  input  logic                        i_RST,
  // Report words from core
  input  sensor_cmd_pkg::report_word_t i_tx_data,
  input  logic                        i_tx_valid,
  output logic                        o_tx_ready,
  // Command words to core
  output sensor_cmd_pkg::cmd_word_t   o_rx_data,
  output logic                        o_rx_valid,
  input  logic                        i_core_busy,
  uart_phy_if.ctrl                    phy
);

  sensor_cmd_pkg::ctrl_state_e  r_state;
  sensor_cmd_pkg::report_word_t r_shift;       // Report, next byte on top
  logic [2:0]                   r_bytes_left;  // Bytes still to hand over

  sensor_cmd_pkg::cmd_e w_rx_op;
  logic                 w_is_stop;       // STOP or either FINISH
  logic                 w_is_read;       // Register read request
  logic                 w_accept_single; // Single-byte command goes out now
  logic                 w_accept_read;   // First byte of a read
  logic                 w_addr_done;     // Address byte of a read
  logic                 w_tx_take;       // Report word accepted
  logic                 w_tx_next;       // Byte finished on the line

  // ==========================================================
  // Receive decode
  // ==========================================================
  assign w_rx_op   = sensor_cmd_pkg::cmd_e'(phy.rx_byte);
  assign w_is_stop = (w_rx_op == sensor_cmd_pkg::CMD_STOP)       ||
                     (w_rx_op == sensor_cmd_pkg::CMD_ADS_FINISH) ||
                     (w_rx_op == sensor_cmd_pkg::CMD_MPR_FINISH);
  assign w_is_read = (w_rx_op == sensor_cmd_pkg::CMD_MPR_READ) ||
                     (w_rx_op == sensor_cmd_pkg::CMD_ADS_READ);

  // Busy core only hears stop/finish
  assign w_accept_single = (r_state == sensor_cmd_pkg::ST_IDLE) && phy.rx_dv &&
                           (i_core_busy ? w_is_stop
                                        : (w_rx_op == sensor_cmd_pkg::CMD_RUN));
  assign w_accept_read   = (r_state == sensor_cmd_pkg::ST_IDLE) && phy.rx_dv &&
                           !i_core_busy && w_is_read;
  assign w_addr_done     = (r_state == sensor_cmd_pkg::ST_RX_ADDR) && phy.rx_dv;

  // RX byte wins over a report word in the same cycle
  assign w_tx_take = (r_state == sensor_cmd_pkg::ST_IDLE) && !phy.rx_dv &&
                     i_tx_valid && o_tx_ready;
  assign w_tx_next = (r_state == sensor_cmd_pkg::ST_TX_WAIT) && phy.tx_done;

  // ==========================================================
  // Control FSM
  // ==========================================================
  always_ff @(posedge i_CLK or posedge i_RST) begin
    if (i_RST) begin
      r_state      <= sensor_cmd_pkg::ST_IDLE;
      r_bytes_left <= '0;
      o_tx_ready   <= 1'b0;
      o_rx_valid   <= 1'b0;
      phy.tx_dv    <= 1'b0;
    end else begin
      o_rx_valid <= 1'b0;  // Pulses only
      phy.tx_dv  <= 1'b0;
      case (r_state)
        sensor_cmd_pkg::ST_IDLE: begin
          o_tx_ready <= 1'b1;
          if (w_accept_single) begin
            o_rx_valid <= 1'b1;
          end else if (w_accept_read) begin
            o_tx_ready <= 1'b0;  // Hold off reports until address arrives
            r_state    <= sensor_cmd_pkg::ST_RX_ADDR;
          end else if (w_tx_take) begin
            o_tx_ready <= 1'b0;
            r_state    <= sensor_cmd_pkg::ST_TX_INIT;
          end
        end
        sensor_cmd_pkg::ST_RX_ADDR: begin
          if (w_addr_done) begin
            o_rx_valid <= 1'b1;
            r_state    <= sensor_cmd_pkg::ST_IDLE;
          end
        end
        sensor_cmd_pkg::ST_TX_INIT: begin
          case (r_shift.header)
            sensor_cmd_pkg::CMD_ADS_DATA: begin
              r_bytes_left <= 3'(sensor_cmd_pkg::REPORT_LONG_BYTES);
              r_state      <= sensor_cmd_pkg::ST_TX_SEND;
            end
            sensor_cmd_pkg::CMD_MPR_DATA,
            sensor_cmd_pkg::CMD_MPR_READ,
            sensor_cmd_pkg::CMD_ADS_READ: begin
              r_bytes_left <= 3'(sensor_cmd_pkg::REPORT_SHORT_BYTES);
              r_state      <= sensor_cmd_pkg::ST_TX_SEND;
            end
            default: r_state <= sensor_cmd_pkg::ST_IDLE;  // Unknown header dropped
          endcase
        end
        sensor_cmd_pkg::ST_TX_SEND: begin
          phy.tx_dv    <= 1'b1;
          r_bytes_left <= r_bytes_left - 1'b1;
          r_state      <= sensor_cmd_pkg::ST_TX_WAIT;
        end
        sensor_cmd_pkg::ST_TX_WAIT: begin
          if (w_tx_next) begin
            r_state <= (r_bytes_left == '0) ? sensor_cmd_pkg::ST_IDLE
                                            : sensor_cmd_pkg::ST_TX_SEND;
          end
        end
        default: r_state <= sensor_cmd_pkg::ST_IDLE;
      endcase
    end
  end

  // ==========================================================
  // Datapath
  // ==========================================================
  always_ff @(posedge i_CLK) begin
    // Command word assembly
    if (w_accept_single || w_accept_read) o_rx_data.opcode <= w_rx_op;
    if (w_accept_single) o_rx_data.addr <= '0;
    else if (w_addr_done) o_rx_data.addr <= phy.rx_byte;

    // Report shifter, MSB byte first
    if (w_tx_take) begin
      r_shift <= i_tx_data;
    end else if (w_tx_next) begin
      r_shift <= {r_shift[$bits(r_shift)-9:0], 8'h00};
    end

    if (r_state == sensor_cmd_pkg::ST_TX_SEND) phy.tx_byte <= r_shift.header;
  end

endmodule

//--- hdl/sensor_session_regs.sv
// Session registers: core busy flag and last register-read target
`timescale 1ns/1ps

module sensor_session_regs (
  input  logic                      i_CLK,
  input  logic                      i_RST,
  input  sensor_cmd_pkg::cmd_word_t i_cmd,
  input  logic                      i_cmd_valid,
  output logic                      o_core_busy,
  output sensor_cmd_pkg::cmd_e      o_reg_dev,   // 'm' or 'a'
  output uart_link_pkg::byte_t      o_reg_addr
);

  logic w_is_read;  // Read request delivered this cycle

  assign w_is_read = i_cmd_valid &&
                     ((i_cmd.opcode == sensor_cmd_pkg::CMD_MPR_READ) ||
                      (i_cmd.opcode == sensor_cmd_pkg::CMD_ADS_READ));

  // ==========================================================
  // Run state and read device
  // ==========================================================
  always_ff @(posedge i_CLK or posedge i_RST) begin
    if (i_RST) begin
      o_core_busy <= 1'b0;
      o_reg_dev   <= sensor_cmd_pkg::cmd_e'(8'h00);  // No device yet
    end else if (i_cmd_valid) begin
      case (i_cmd.opcode)
        sensor_cmd_pkg::CMD_RUN: o_core_busy <= 1'b1;
        sensor_cmd_pkg::CMD_STOP,
        sensor_cmd_pkg::CMD_ADS_FINISH,
        sensor_cmd_pkg::CMD_MPR_FINISH: o_core_busy <= 1'b0;
        sensor_cmd_pkg::CMD_MPR_READ,
        sensor_cmd_pkg::CMD_ADS_READ: o_reg_dev <= i_cmd.opcode;
        default: ;  // Other opcodes never reach here
      endcase
    end
  end

  // Register address of last read
  always_ff @(posedge i_CLK) begin
    if (w_is_read) o_reg_addr <= i_cmd.addr;
  end

endmodule

//--- hdl/uart_sensor_top.sv
// Top level of the PC command link: UART engines, controller, session registers
`timescale 1ns/1ps

module uart_sensor_top #(
  parameter int CLKS_PER_BIT = uart_link_pkg::CLKS_PER_BIT_DEFAULT
) (
  input  logic        i_CLK,
  input  logic        i_RST,
  // Serial pins
  input  logic        i_uart_rxd,
  output logic        o_uart_txd,
  // Report words from core
  input  logic [39:0] i_tx_data,
  input  logic        i_tx_valid,
  output logic        o_tx_ready,
  // Command words to core
  output logic [15:0] o_rx_data,
  output logic        o_rx_valid,
  // Session state
  output logic        o_core_busy,
  output logic [7:0]  o_reg_dev,
  output logic [7:0]  o_reg_addr
);

  uart_phy_if phy_bus ();  // Controller <-> engines

  // ==========================================================
  // UART engines
  // ==========================================================
  uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart_tx (
    .i_CLK (i_CLK),
    .i_RST (i_RST),
    .phy   (phy_bus.tx),
    .o_txd (o_uart_txd)
  );

  uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart_rx (
    .i_CLK (i_CLK),
    .i_RST (i_RST),
    .i_rxd (i_uart_rxd),
    .phy   (phy_bus.rx)
  );

  // ==========================================================
  // Command handling
  // ==========================================================
  uart_controller u_uart_controller (
    .i_CLK       (i_CLK),
    .i_RST       (i_RST),
    .i_tx_data   (i_tx_data),
    .i_tx_valid  (i_tx_valid),
    .o_tx_ready  (o_tx_ready),
    .o_rx_data   (o_rx_data),
    .o_rx_valid  (o_rx_valid),
    .i_core_busy (o_core_busy),   // Filter steered by session state
    .phy         (phy_bus.ctrl)
  );

  sensor_session_regs u_sensor_session_regs (
    .i_CLK       (i_CLK),
    .i_RST       (i_RST),
    .i_cmd       (o_rx_data),
    .i_cmd_valid (o_rx_valid),
    .o_core_busy (o_core_busy),
    .o_reg_dev   (o_reg_dev),
    .o_reg_addr  (o_reg_addr)
  );

endmodule

//--- testbench/tb_uart_sensor_top.sv
// UART sensor link testbench with clock, reset, serial driver and decoder, model and checks
`timescale 1ns/1ps

module tb_uart_sensor_top;

  localparam int CPB  = 8;             // Clocks per bit in simulation
  localparam int SEED = 32'h3859d6cf;

  logic        i_CLK;
  logic        i_RST;
  logic        i_uart_rxd;
  logic        o_uart_txd;
  logic [39:0] i_tx_data;
  logic        i_tx_valid;
  logic        o_tx_ready;
  logic [15:0] o_rx_data;
  logic        o_rx_valid;
  logic        o_core_busy;
  logic [7:0]  o_reg_dev;
  logic [7:0]  o_reg_addr;

  logic [15:0] rx_words[$];  // Command words seen on o_rx_valid
  logic [7:0]  tx_bytes[$];  // Bytes decoded from o_uart_txd

  // Reference model state
  bit          m_busy;
  bit          m_pend;       // Read opcode seen, address byte next
  bit          m_have_read;
  logic [7:0]  m_pend_op;
  logic [7:0]  m_dev;
  logic [7:0]  m_addr;

  int err_cnt;
  int tmo_cnt;
  int chk_cnt;

  uart_sensor_top #(.CLKS_PER_BIT(CPB)) u_uart_sensor_top (
    .i_CLK       (i_CLK),
    .i_RST       (i_RST),
    .i_uart_rxd  (i_uart_rxd),
    .o_uart_txd  (o_uart_txd),
    .i_tx_data   (i_tx_data),
    .i_tx_valid  (i_tx_valid),
    .o_tx_ready  (o_tx_ready),
    .o_rx_data   (o_rx_data),
    .o_rx_valid  (o_rx_valid),
    .o_core_busy (o_core_busy),
    .o_reg_dev   (o_reg_dev),
    .o_reg_addr  (o_reg_addr)
  );

  initial begin
    i_CLK = 1'b0;
    forever #50 i_CLK = ~i_CLK;  // 100 ns period
  end

  // ==========================================================
  // Monitors sampled on the falling edge
  // ==========================================================
  always @(negedge i_CLK) begin
    if (!i_RST && o_rx_valid) rx_words.push_back(o_rx_data);
  end

  int         dec_cnt;
  int         dec_bit;
  bit         dec_on;
  logic [7:0] dec_shift;

  // Serial decoder with mid-bit sampling from the start edge
  always @(negedge i_CLK) begin
    if (i_RST) begin
      dec_on = 1'b0;
    end else if (!dec_on) begin
      if (!o_uart_txd) begin
        dec_on  = 1'b1;
        dec_cnt = 0;
        dec_bit = 0;
      end
    end else begin
      dec_cnt = dec_cnt + 1;
      if (dec_cnt == CPB / 2 + CPB * (dec_bit + 1)) begin
        if (dec_bit < 8) begin
          dec_shift = {o_uart_txd, dec_shift[7:1]};  // LSB first
          dec_bit   = dec_bit + 1;
        end else begin
          if (!o_uart_txd) begin
            err_cnt++;
            $display("[ERROR] %0t ns: stop bit low on o_uart_txd", $time);
          end
          tx_bytes.push_back(dec_shift);
          dec_on = 1'b0;
        end
      end
    end
  end

  // ==========================================================
  // Helpers
  // ==========================================================
  task automatic report_timeout(input string what);
    sensor_cmd_pkg::ctrl_state_e st;
    st = u_uart_sensor_top.u_uart_controller.r_state;
    tmo_cnt++;
    $display("Timeout at %0t ns waiting for %s, controller in %s", $time, what, st.name());
  endtask

  task automatic check_value(input string what, input logic [39:0] got, input logic [39:0] exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("[ERROR] %0t ns: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  // One 8N1 frame on i_uart_rxd
  task automatic send_serial(input logic [7:0] b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(negedge i_CLK);
      i_uart_rxd = frame[i];
      repeat (CPB - 1) @(negedge i_CLK);
    end
  endtask

  // Filter rules of the link applied one byte at a time
  task automatic model_byte(input logic [7:0] b, output bit have, output logic [15:0] word);
    have = 1'b0;
    word = '0;
    if (m_pend) begin                            // Address byte completes the read
      have        = 1'b1;
      word        = {m_pend_op, b};
      m_pend      = 1'b0;
      m_dev       = m_pend_op;
      m_addr      = b;
      m_have_read = 1'b1;
    end else if (m_busy) begin
      if (b == "S" || b == "F" || b == "f") begin
        have   = 1'b1;
        word   = {b, 8'h00};
        m_busy = 1'b0;
      end
    end else if (b == "R") begin
      have   = 1'b1;
      word   = {b, 8'h00};
      m_busy = 1'b1;
    end else if (b == "m" || b == "a") begin
      m_pend    = 1'b1;
      m_pend_op = b;
    end
  endtask

  task automatic rx_step(input logic [7:0] b);
    bit          have;
    logic [15:0] exp_w;
    int          t;
    model_byte(b, have, exp_w);
    send_serial(b);
    t = 0;
    while (have && rx_words.size() == 0 && t < 4 * CPB) begin
      @(negedge i_CLK);
      t++;
    end
    if (have && rx_words.size() == 0) report_timeout("o_rx_valid");
    else if (have) check_value("o_rx_data", rx_words.pop_front(), exp_w);
    repeat (2 * CPB) @(negedge i_CLK);           // Quiet window for stray pulses
    chk_cnt++;
    if (rx_words.size() != 0) begin
      err_cnt++;
      $display("[ERROR] %0t ns: unexpected o_rx_valid after byte %h", $time, b);
      rx_words.delete();
    end
    check_value("o_core_busy", o_core_busy, m_busy);
    check_value("o_reg_dev", o_reg_dev, m_dev);
    if (m_have_read) check_value("o_reg_addr", o_reg_addr, m_addr);
  endtask

  task automatic report_step(input logic [39:0] w);
    int n;
    int t;
    n = (w[39:32] == "A") ? 5 : (w[39:32] == "M" || w[39:32] == "m" || w[39:32] == "a") ? 3 : 0;
    tx_bytes.delete();
    @(negedge i_CLK);
    t = 0;
    while (!o_tx_ready && t < 20) begin
      @(negedge i_CLK);
      t++;
    end
    if (!o_tx_ready) report_timeout("o_tx_ready before a report");
    i_tx_data  = w;
    i_tx_valid = 1'b1;
    @(negedge i_CLK);
    i_tx_valid = 1'b0;
    i_tx_data  = 40'($urandom);                  // Junk once accepted
    check_value("o_tx_ready after accept", o_tx_ready, 1'b0);
    t = 0;
    while (!o_tx_ready && t < 12 * CPB * 6) begin
      @(negedge i_CLK);
      t++;
    end
    if (!o_tx_ready) report_timeout("o_tx_ready after a report");
    repeat (2) @(negedge i_CLK);
    check_value("report byte count", tx_bytes.size(), n);
    for (int k = 0; k < n && k < tx_bytes.size(); k++) begin
      check_value("report byte", tx_bytes[k], w[39 - 8 * k -: 8]);
    end
  endtask

  // ==========================================================
  // Stimulus
  // ==========================================================
  initial begin
    int         seed_ret;
    int         t;
    logic [7:0] hdr;
    seed_ret   = $urandom(SEED);
    i_RST      = 1'b1;
    i_uart_rxd = 1'b1;
    i_tx_data  = '0;
    i_tx_valid = 1'b0;
    err_cnt    = 0;
    tmo_cnt    = 0;
    chk_cnt    = 0;
    m_busy     = 1'b0;
    m_pend     = 1'b0;
    m_dev      = 8'h00;
    m_have_read = 1'b0;
    repeat (10) @(negedge i_CLK);
    check_value("o_uart_txd in reset", o_uart_txd, 1'b1);
    check_value("o_rx_valid in reset", o_rx_valid, 1'b0);
    check_value("o_core_busy in reset", o_core_busy, 1'b0);
    check_value("o_tx_ready in reset", o_tx_ready, 1'b0);
    i_RST = 1'b0;
    t = 0;
    while (!o_tx_ready && t < 5) begin
      @(negedge i_CLK);
      t++;
    end
    if (!o_tx_ready) report_timeout("o_tx_ready after reset");

    // Random command traffic where busy toggles along the way
    for (int i = 0; i < 50; i++) begin
      case ($urandom_range(4, 0))
        0: rx_step("R");
        1: rx_step($urandom_range(1, 0) ? "S" : ($urandom_range(1, 0) ? "F" : "f"));
        2, 3: begin
          rx_step($urandom_range(1, 0) ? "m" : "a");
          rx_step(8'($urandom));                 // Address or a filtered byte
        end
        default: rx_step(8'($urandom));
      endcase
    end

    // Close a read left open by a random 'm' or 'a'
    if (m_pend) rx_step(8'($urandom));

    // Report words with known and unknown headers
    for (int i = 0; i < 30; i++) begin
      case ($urandom_range(5, 0))
        0: hdr = "A";
        1: hdr = "M";
        2: hdr = "m";
        3: hdr = "a";
        default: hdr = 8'($urandom);
      endcase
      report_step({hdr, 32'($urandom)});
    end

    $display("Checks: %0d  errors: %0d  timeouts: %0d", chk_cnt, err_cnt, tmo_cnt);
    if (err_cnt == 0 && tmo_cnt == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

//--- files.f
hdl/uart_link_pkg.sv
hdl/sensor_cmd_pkg.sv
hdl/uart_phy_if.sv
hdl/uart_tx.sv
hdl/uart_rx.sv
hdl/uart_controller.sv
hdl/sensor_session_regs.sv
hdl/uart_sensor_top.sv
testbench/tb_uart_sensor_top.sv
